// File: lock_mgr_pkg.sv
package lock_mgr_pkg;

  // **************************************************
  // Sizes
  // **************************************************

  // Accelerators sharing the lock manager
  localparam int unsigned num_accs = 4;
  localparam int unsigned acc_id_bits = 2;

  // Lock table
  localparam int unsigned num_locks = 4;
  localparam int unsigned lock_id_bits = 2;

  // Stream widths
  localparam int unsigned cmd_word_bits = 64;
  localparam int unsigned ack_bits = 8;

  // **************************************************
  // Command word layout
  // **************************************************

  // Command type sits in the low byte
  localparam int unsigned cmd_type_bits = 8;
  // Lock id follows right above the command type
  // Everything above the lock id is unused by the lock unit
  localparam int unsigned reserved_bits = cmd_word_bits - cmd_type_bits - lock_id_bits;

  // **************************************************
  // Command and acknowledge codes
  // **************************************************

  localparam logic [cmd_type_bits-1:0] cmd_lock_code = 8'h01;
  localparam logic [cmd_type_bits-1:0] cmd_unlock_code = 8'h02;

  // Lock was free and is now taken
  localparam logic [ack_bits-1:0] ack_ok_code = 8'h01;
  // Lock was already held
  localparam logic [ack_bits-1:0] ack_reject_code = 8'h00;

  // **************************************************
  // Lock unit FSM encoding
  // **************************************************

  localparam int unsigned state_bits = 2;
  localparam logic [state_bits-1:0] st_read_header = 2'd0;
  localparam logic [state_bits-1:0] st_check_lock = 2'd1;
  localparam logic [state_bits-1:0] st_send_ack = 2'd2;

  // Two views of one command word
  // raw is passed along untouched, hdr is what the lock unit decodes
  typedef union packed {
    logic [cmd_word_bits-1:0] raw;
    struct packed {
      logic [reserved_bits-1:0] reserved;
      logic [lock_id_bits-1:0] lock_id;
      logic [cmd_type_bits-1:0] cmd_type;
    } hdr;
  } lock_cmd_u;

endpackage

// File: lock_cmd_arbiter.sv
`timescale 1ns/100ps

module lock_cmd_arbiter (
  input  logic ap_clk,
  input  logic ap_rst_n,
  // Accelerator command streams
  input  logic [lock_mgr_pkg::num_accs-1:0] cmd_valid,
  input  logic [lock_mgr_pkg::num_accs-1:0][lock_mgr_pkg::cmd_word_bits-1:0] cmd_data,
  output logic [lock_mgr_pkg::num_accs-1:0] cmd_ready,
  // Merged stream towards the lock unit
  output logic arb_valid,
  output logic [lock_mgr_pkg::cmd_word_bits-1:0] arb_data,
  output logic [lock_mgr_pkg::acc_id_bits-1:0] arb_acc_id,
  input  logic arb_ready
);

  // Round-robin pointer, first accelerator to look at
  logic [lock_mgr_pkg::acc_id_bits-1:0] rr_ptr;
  // Accelerator currently under test in the scan
  logic [lock_mgr_pkg::acc_id_bits-1:0] scan_id;
  // Winner of this cycle
  logic [lock_mgr_pkg::acc_id_bits-1:0] grant_id;
  logic grant_found;
  // Output register empty or being drained this cycle
  logic out_free;
  // A command is taken into the output register
  logic take;

  // **************************************************
  // Grant selection
  // **************************************************

  // Scan from rr_ptr upwards, wrapping at num_accs
  always_comb begin
    grant_found = 1'b0;
    grant_id = rr_ptr;
    scan_id = rr_ptr;
    for (int i = 0; i < lock_mgr_pkg::num_accs; i++) begin
      scan_id = rr_ptr + i[lock_mgr_pkg::acc_id_bits-1:0];
      if (!grant_found && cmd_valid[scan_id]) begin
        grant_found = 1'b1;
        grant_id = scan_id;
      end
    end
  end

  assign out_free = !arb_valid || arb_ready;
  assign take = grant_found && out_free;

  // Only the granted accelerator sees ready
  always_comb begin
    cmd_ready = '0;
    if (take) begin
      cmd_ready[grant_id] = 1'b1;
    end
  end

  // **************************************************
  // Output register
  // **************************************************

  // Valid and priority pointer
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      arb_valid <= 1'b0;
      rr_ptr <= '0;
    end else begin
      if (take) begin
        arb_valid <= 1'b1;
        // Next search starts just past the one served
        rr_ptr <= grant_id + 1'b1;
      end else if (arb_ready) begin
        arb_valid <= 1'b0;
      end
    end
  end

  // Payload with the sender id as tag
  always_ff @(posedge ap_clk) begin
    if (take) begin
      arb_data <= cmd_data[grant_id];
      arb_acc_id <= grant_id;
    end
  end

endmodule

// File: lock_unit.sv
`timescale 1ns/100ps

module lock_unit (
  input  logic ap_clk,
  input  logic ap_rst_n,
  // Tagged command stream from the arbiter
  input  logic arb_valid,
  input  logic [lock_mgr_pkg::cmd_word_bits-1:0] arb_data,
  input  logic [lock_mgr_pkg::acc_id_bits-1:0] arb_acc_id,
  output logic arb_ready,
  // Acknowledge stream to the router
  output logic ack_valid,
  output logic [lock_mgr_pkg::ack_bits-1:0] ack_data,
  output logic [lock_mgr_pkg::acc_id_bits-1:0] ack_dest,
  input  logic ack_ready
);

  // FSM state
  logic [lock_mgr_pkg::state_bits-1:0] state;

  // One bit per lock, set means held
  logic [lock_mgr_pkg::num_locks-1:0] lock_table;

  // Incoming word seen through the union
  lock_mgr_pkg::lock_cmd_u cmd_in;

  // Captured command fields
  logic [lock_mgr_pkg::cmd_type_bits-1:0] cmd_type_q;
  logic [lock_mgr_pkg::lock_id_bits-1:0] lock_id_q;
  // Sender of the command, becomes the ack destination
  logic [lock_mgr_pkg::acc_id_bits-1:0] acc_id_q;
  // Pending acknowledge code
  logic [lock_mgr_pkg::ack_bits-1:0] ack_code_q;

  assign cmd_in.raw = arb_data;

  // **************************************************
  // Stream handshakes
  // **************************************************

  // Accept commands only while idle
  assign arb_ready = (state == lock_mgr_pkg::st_read_header);

  // Ack is offered for as long as the FSM waits in SEND_ACK
  assign ack_valid = (state == lock_mgr_pkg::st_send_ack);
  assign ack_data = ack_code_q;
  assign ack_dest = acc_id_q;

  // **************************************************
  // Command capture
  // **************************************************

  // Decode through the hdr view on the transfer
  always_ff @(posedge ap_clk) begin
    if (state == lock_mgr_pkg::st_read_header && arb_valid) begin
      cmd_type_q <= cmd_in.hdr.cmd_type;
      lock_id_q <= cmd_in.hdr.lock_id;
      acc_id_q <= arb_acc_id;
    end
  end

  // **************************************************
  // FSM and lock table
  // **************************************************

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state <= lock_mgr_pkg::st_read_header;
      lock_table <= '0;
    end else begin
      case (state)
        lock_mgr_pkg::st_read_header: begin
          if (arb_valid) begin
            state <= lock_mgr_pkg::st_check_lock;
          end
        end

        lock_mgr_pkg::st_check_lock: begin
          if (cmd_type_q == lock_mgr_pkg::cmd_lock_code) begin
            // Test and set, lock ends up held either way
            lock_table[lock_id_q] <= 1'b1;
            state <= lock_mgr_pkg::st_send_ack;
          end else begin
            // Unlock needs no ack
            if (cmd_type_q == lock_mgr_pkg::cmd_unlock_code) begin
              lock_table[lock_id_q] <= 1'b0;
            end
            // Unknown codes are simply dropped
            state <= lock_mgr_pkg::st_read_header;
          end
        end

        lock_mgr_pkg::st_send_ack: begin
          // Stall here while the router buffer is full
          if (ack_ready) begin
            state <= lock_mgr_pkg::st_read_header;
          end
        end

        default: begin
          state <= lock_mgr_pkg::st_read_header;
        end
      endcase
    end
  end

  // Ack code depends on the lock bit before the set
  always_ff @(posedge ap_clk) begin
    if (state == lock_mgr_pkg::st_check_lock) begin
      if (lock_table[lock_id_q]) begin
        ack_code_q <= lock_mgr_pkg::ack_reject_code;
      end else begin
        ack_code_q <= lock_mgr_pkg::ack_ok_code;
      end
    end
  end

endmodule

// File: lock_ack_router.sv
`timescale 1ns/100ps

module lock_ack_router (
  input  logic ap_clk,
  input  logic ap_rst_n,
  // Acknowledge stream from the lock unit
  input  logic ack_valid,
  input  logic [lock_mgr_pkg::ack_bits-1:0] ack_data,
  input  logic [lock_mgr_pkg::acc_id_bits-1:0] ack_dest,
  output logic ack_ready,
  // Per-accelerator acknowledge streams
  output logic [lock_mgr_pkg::num_accs-1:0] acc_ack_valid,
  output logic [lock_mgr_pkg::num_accs-1:0][lock_mgr_pkg::ack_bits-1:0] acc_ack_data,
  input  logic [lock_mgr_pkg::num_accs-1:0] acc_ack_ready
);

  // One-entry buffer per accelerator
  logic [lock_mgr_pkg::num_accs-1:0] buf_valid;
  logic [lock_mgr_pkg::num_accs-1:0][lock_mgr_pkg::ack_bits-1:0] buf_data;

  // Ack transfer from the lock unit this cycle
  logic fill;

  // Only the addressed buffer decides back-pressure
  assign ack_ready = !buf_valid[ack_dest];
  assign fill = ack_valid && ack_ready;

  assign acc_ack_valid = buf_valid;
  assign acc_ack_data = buf_data;

  // **************************************************
  // Buffer control
  // **************************************************

  // Each buffer drains on its own, so a slow
  // accelerator only holds up its own acks
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      buf_valid <= '0;
    end else begin
      for (int i = 0; i < lock_mgr_pkg::num_accs; i++) begin
        if (buf_valid[i] && acc_ack_ready[i]) begin
          buf_valid[i] <= 1'b0;
        end
        // Fill only happens into an empty buffer
        if (fill && ack_dest == i[lock_mgr_pkg::acc_id_bits-1:0]) begin
          buf_valid[i] <= 1'b1;
        end
      end
    end
  end

  // Ack payload, loaded into the addressed slot
  always_ff @(posedge ap_clk) begin
    if (fill) begin
      buf_data[ack_dest] <= ack_data;
    end
  end

endmodule

// File: lock_mgr_top.sv
`timescale 1ns/100ps

module lock_mgr_top (
  input  logic ap_clk,
  input  logic ap_rst_n,
  // Command streams from the accelerators
  input  logic [lock_mgr_pkg::num_accs-1:0] cmd_valid,
  input  logic [lock_mgr_pkg::num_accs-1:0][lock_mgr_pkg::cmd_word_bits-1:0] cmd_data,
  output logic [lock_mgr_pkg::num_accs-1:0] cmd_ready,
  // Acknowledge streams back to the accelerators
  output logic [lock_mgr_pkg::num_accs-1:0] acc_ack_valid,
  output logic [lock_mgr_pkg::num_accs-1:0][lock_mgr_pkg::ack_bits-1:0] acc_ack_data,
  input  logic [lock_mgr_pkg::num_accs-1:0] acc_ack_ready
);

  // Arbiter to lock unit
  logic arb_valid;
  logic arb_ready;
  logic [lock_mgr_pkg::cmd_word_bits-1:0] arb_data;
  logic [lock_mgr_pkg::acc_id_bits-1:0] arb_acc_id;

  // Lock unit to router
  logic ack_valid;
  logic ack_ready;
  logic [lock_mgr_pkg::ack_bits-1:0] ack_data;
  logic [lock_mgr_pkg::acc_id_bits-1:0] ack_dest;

  // **************************************************
  // Command merge
  // **************************************************

  lock_cmd_arbiter i_arbiter (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_data   (cmd_data),
    .cmd_ready  (cmd_ready),
    .arb_valid  (arb_valid),
    .arb_data   (arb_data),
    .arb_acc_id (arb_acc_id),
    .arb_ready  (arb_ready)
  );

  // **************************************************
  // Lock table
  // **************************************************

  lock_unit i_lock_unit (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .arb_valid  (arb_valid),
    .arb_data   (arb_data),
    .arb_acc_id (arb_acc_id),
    .arb_ready  (arb_ready),
    .ack_valid  (ack_valid),
    .ack_data   (ack_data),
    .ack_dest   (ack_dest),
    .ack_ready  (ack_ready)
  );

  // Acks go back to the issuing accelerator
  lock_ack_router i_router (
    .ap_clk        (ap_clk),
    .ap_rst_n      (ap_rst_n),
    .ack_valid     (ack_valid),
    .ack_data      (ack_data),
    .ack_dest      (ack_dest),
    .ack_ready     (ack_ready),
    .acc_ack_valid (acc_ack_valid),
    .acc_ack_data  (acc_ack_data),
    .acc_ack_ready (acc_ack_ready)
  );

endmodule

// File: lock_mgr_tb.sv
`timescale 1ns/100ps

module lock_mgr_tb;

  // **************************************************
  // DUT signals
  // **************************************************

  logic ap_clk;
  logic ap_rst_n;
  logic [lock_mgr_pkg::num_accs-1:0] cmd_valid;
  logic [lock_mgr_pkg::num_accs-1:0][lock_mgr_pkg::cmd_word_bits-1:0] cmd_data;
  logic [lock_mgr_pkg::num_accs-1:0] cmd_ready;
  logic [lock_mgr_pkg::num_accs-1:0] acc_ack_valid;
  logic [lock_mgr_pkg::num_accs-1:0][lock_mgr_pkg::ack_bits-1:0] acc_ack_data;
  logic [lock_mgr_pkg::num_accs-1:0] acc_ack_ready;

  // Lock table as seen from outside for picking a free id in the race case
  logic [lock_mgr_pkg::num_locks-1:0] model_locks;

  localparam int wait_limit = 200;
  // Expected code in the case file that means no ack
  localparam logic [7:0] no_ack = 8'hff;

  lock_mgr_top i_dut (
    .ap_clk        (ap_clk),
    .ap_rst_n      (ap_rst_n),
    .cmd_valid     (cmd_valid),
    .cmd_data      (cmd_data),
    .cmd_ready     (cmd_ready),
    .acc_ack_valid (acc_ack_valid),
    .acc_ack_data  (acc_ack_data),
    .acc_ack_ready (acc_ack_ready)
  );

  // 40 ns period
  always #20 ap_clk = ~ap_clk;

  // **************************************************
  // Checking helpers
  // **************************************************

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      stop_on_error($sformatf("FAIL %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // Reserved bits carry a pattern the lock unit has to ignore
  function automatic logic [63:0] make_word(input logic [7:0] code, input logic [1:0] id);
    return {{27{2'b10}}, id, code};
  endfunction

  // **************************************************
  // Stream drivers
  // **************************************************

  // Every task starts and ends 2 ns after a rising edge
  task automatic send_command(input logic [1:0] acc, input logic [63:0] word,
                              input string name);
    int cycles;
    cycles = 0;
    cmd_data[acc] = word;
    cmd_valid[acc] = 1'b1;
    @(negedge ap_clk);
    while (!cmd_ready[acc]) begin
      cycles++;
      if (cycles > wait_limit) stop_on_error({"Timeout waiting for cmd_ready in ", name});
      @(negedge ap_clk);
    end
    // Ready seen mid-cycle so the transfer happens on the coming edge
    @(posedge ap_clk);
    #2;
    cmd_valid[acc] = 1'b0;
  endtask

  task automatic expect_ack(input logic [1:0] acc, input logic [7:0] expected,
                            input string name);
    logic [3:0] others;
    int cycles;
    int stall;
    others = ~(4'b0001 << acc);
    cycles = 0;
    @(negedge ap_clk);
    while (!acc_ack_valid[acc]) begin
      check_value({name, " stray ack"}, 0, acc_ack_valid & others);
      cycles++;
      if (cycles > wait_limit) stop_on_error({"Timeout waiting for acc_ack_valid in ", name});
      @(negedge ap_clk);
    end
    check_value({name, " stray ack"}, 0, acc_ack_valid & others);
    check_value(name, expected, acc_ack_data[acc]);
    // Accelerator not ready for a while
    stall = $urandom % 6;
    repeat (stall) begin
      @(negedge ap_clk);
      check_value({name, " valid held"}, 1, acc_ack_valid[acc]);
      check_value({name, " data held"}, expected, acc_ack_data[acc]);
    end
    @(posedge ap_clk);
    #2;
    acc_ack_ready[acc] = 1'b1;
    @(posedge ap_clk);
    #2;
    acc_ack_ready[acc] = 1'b0;
    @(negedge ap_clk);
    check_value({name, " ack cleared"}, 0, acc_ack_valid[acc]);
    @(posedge ap_clk);
    #2;
  endtask

  // Unlock and unknown codes must not produce any ack
  task automatic expect_quiet(input string name);
    repeat (20) begin
      @(negedge ap_clk);
      check_value({name, " no ack"}, 0, acc_ack_valid);
    end
    @(posedge ap_clk);
    #2;
  endtask

  task automatic run_case(input logic [1:0] acc, input logic [7:0] code,
                          input logic [1:0] id, input logic [7:0] expected,
                          input string name);
    send_command(acc, make_word(code, id), name);
    if (code == lock_mgr_pkg::cmd_lock_code) model_locks[id] = 1'b1;
    if (code == lock_mgr_pkg::cmd_unlock_code) model_locks[id] = 1'b0;
    if (expected == no_ack) begin
      expect_quiet(name);
    end else begin
      expect_ack(acc, expected, name);
    end
  endtask

  // **************************************************
  // Race between accelerators 0 and 1
  // **************************************************

  task automatic concurrent_lock();
    logic [1:0] id;
    logic [1:0] got;
    logic [1:0] taken;
    logic [7:0] acks [2];
    int cycles;
    int ok_count;
    int reject_count;
    id = 2'd0;
    got = 2'b00;
    for (int i = lock_mgr_pkg::num_locks - 1; i >= 0; i--) begin
      if (!model_locks[i]) id = i[1:0];
    end
    if (model_locks[id]) stop_on_error("No free lock left for the concurrent lock case");
    cmd_data[0] = make_word(lock_mgr_pkg::cmd_lock_code, id);
    cmd_data[1] = make_word(lock_mgr_pkg::cmd_lock_code, id);
    cmd_valid[1:0] = 2'b11;
    acc_ack_ready[1:0] = 2'b11;
    cycles = 0;
    // Ready held high so each ack is valid for exactly one cycle
    while (got != 2'b11) begin
      @(negedge ap_clk);
      for (int k = 0; k < 2; k++) begin
        if (acc_ack_valid[k] && !got[k]) begin
          acks[k] = acc_ack_data[k];
          got[k] = 1'b1;
        end
      end
      taken = cmd_valid[1:0] & cmd_ready[1:0];
      // The arbiter takes one requester per cycle at most
      if (taken == 2'b11) stop_on_error("Arbiter accepted both accelerators in one cycle");
      cycles++;
      if (cycles > wait_limit) stop_on_error("Timeout waiting for both acks of the race");
      @(posedge ap_clk);
      #2;
      cmd_valid[1:0] = cmd_valid[1:0] & ~taken;
    end
    acc_ack_ready[1:0] = 2'b00;
    model_locks[id] = 1'b1;
    ok_count = (acks[0] == lock_mgr_pkg::ack_ok_code) + (acks[1] == lock_mgr_pkg::ack_ok_code);
    reject_count = (acks[0] == lock_mgr_pkg::ack_reject_code) +
                   (acks[1] == lock_mgr_pkg::ack_reject_code);
    check_value("concurrent lock ok count", 1, ok_count);
    check_value("concurrent lock reject count", 1, reject_count);
  endtask

  // **************************************************
  // Main sequence
  // **************************************************

  initial begin
    int fd;
    int seed;
    int line_no;
    int acc_i;
    int code_i;
    int id_i;
    int exp_i;
    string line;
    seed = $urandom(9);
    ap_clk = 1'b0;
    ap_rst_n = 1'b0;
    cmd_valid = '0;
    cmd_data = '0;
    acc_ack_ready = '0;
    model_locks = '0;
    repeat (10) @(posedge ap_clk);
    #2;
    ap_rst_n = 1'b1;
    fd = $fopen("lock_mgr_cases.txt", "r");
    if (fd == 0) stop_on_error("Cannot open lock_mgr_cases.txt");
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      line_no++;
      // Comment lines start with # and blank lines are skipped
      if ($fgets(line, fd) > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h %h", acc_i, code_i, id_i, exp_i) == 4) begin
          run_case(acc_i[1:0], code_i[7:0], id_i[1:0], exp_i[7:0],
                   $sformatf("case line %0d", line_no));
        end
      end
    end
    $fclose(fd);
    concurrent_lock();
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: lock_mgr_cases.txt
# accelerator command_code lock_id expected_ack (hex, ff = no ack expected)
# lock codes 01 lock, 02 unlock, anything else is dropped
0 01 0 01
1 01 0 00
2 01 0 00
3 02 0 ff
1 01 0 01
0 01 1 01
2 01 2 01
3 01 3 01
1 01 1 00
2 7e 1 ff
0 01 3 00
3 02 2 ff
3 02 1 ff
2 01 1 01
0 00 0 ff
3 01 2 01
1 02 0 ff
2 01 0 01
0 02 0 ff

// File: lock_mgr_top.f
lock_mgr_pkg.sv
lock_cmd_arbiter.sv
lock_unit.sv
lock_ack_router.sv
lock_mgr_top.sv
lock_mgr_tb.sv

// File: Makefile
TOP = lock_mgr_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal -f lock_mgr_top.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
